/* source/uart_alu_pkg.sv */
package uart_alu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Clocking and UART frame format.
  ////////////////////////////////////////////////////////////////////////////

  localparam int CLK_FREQ_HZ = 10_000_000;  // System clock.
  localparam int BAUD_RATE   = 115_200;     // Line rate.
  localparam int OVERSAMPLE  = 16;          // Ticks per bit.
  localparam int BAUD_DIV    =              // Clocks per tick, rounded.
    (CLK_FREQ_HZ + (BAUD_RATE * OVERSAMPLE) / 2) / (BAUD_RATE * OVERSAMPLE);
  localparam int BAUD_CNT_W  = $clog2(BAUD_DIV);  // Divider counter width.
  localparam int DATA_BITS   = 8;           // Payload bits per frame.
  localparam int STOP_BITS   = 2;           // Stop bits per frame.

  // Vector types.
  typedef logic [DATA_BITS-1:0]           byte_t;      // Data or operand.
  typedef logic [7:0]                     opcode_t;    // ALU opcode.
  typedef logic [$clog2(OVERSAMPLE)-1:0]  tick_cnt_t;  // Ticks inside a bit.
  typedef logic [$clog2(DATA_BITS)-1:0]   bit_cnt_t;   // Bit index.

  // Counter end points.
  localparam tick_cnt_t TICK_MID  = tick_cnt_t'(OVERSAMPLE / 2 - 1);  // Mid bit.
  localparam tick_cnt_t TICK_LAST = tick_cnt_t'(OVERSAMPLE - 1);      // Bit end.
  localparam bit_cnt_t  BIT_LAST  = bit_cnt_t'(DATA_BITS - 1);        // MSB.
  localparam bit_cnt_t  STOP_LAST = bit_cnt_t'(STOP_BITS - 1);        // Last stop.

  ////////////////////////////////////////////////////////////////////////////
  // ALU opcodes.
  ////////////////////////////////////////////////////////////////////////////

  localparam opcode_t OP_ADD = 8'h20;  // A + B.
  localparam opcode_t OP_SUB = 8'h22;  // A - B.
  localparam opcode_t OP_AND = 8'h24;
  localparam opcode_t OP_OR  = 8'h25;
  localparam opcode_t OP_XOR = 8'h26;
  localparam opcode_t OP_NOR = 8'h27;
  localparam opcode_t OP_SRL = 8'h02;  // Logical right shift.
  localparam opcode_t OP_SRA = 8'h03;  // Arithmetic right shift.

  // State machines.
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
  typedef enum logic [1:0] {C_GET_A, C_GET_B, C_GET_OP, C_SEND} ctrl_state_t;

endpackage

/* source/baud_tick_gen.sv */
`timescale 1ns/1ps

module baud_tick_gen
  import uart_alu_pkg::*;
(
  input  logic i_clock,  // System clock.
  input  logic i_rst_n,  // Sync reset, active low.
  output logic o_tick    // 16x oversampling strobe.
);

  logic [BAUD_CNT_W-1:0] div_cnt;  // Clocks since last tick.
  logic                  wrap;     // Counter at its end value.

  assign wrap = (div_cnt == BAUD_CNT_W'(BAUD_DIV - 1));

  // Free running divider.
  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      div_cnt <= '0;
      o_tick  <= 1'b0;
    end else begin
      o_tick <= wrap;  // One clock wide.
      if (wrap) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

/* source/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx
  import uart_alu_pkg::*;
(
  input  logic  i_clock,  // System clock.
  input  logic  i_rst_n,  // Sync reset, active low.
  input  logic  i_tick,   // Oversampling strobe.
  input  logic  i_rxd,    // Serial line, idle high.
  output byte_t o_data,   // Last good byte.
  output logic  o_valid   // One clock per good frame.
);

  logic      rxd_meta;   // First sync stage.
  logic      rxd_sync;   // Line, safe to use.
  rx_state_t state;
  tick_cnt_t tick_cnt;   // Ticks into the current bit.
  bit_cnt_t  bit_cnt;    // Data bit being received.
  byte_t     shift_reg;  // Assembles the byte, LSB first.

  // Two flop synchronizer; line idles high.
  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= i_rxd;
      rxd_sync <= rxd_meta;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Frame FSM. Sampling points sit mid bit after the start check.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      state    <= RX_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      o_valid  <= 1'b0;
      o_data   <= '0;  // Keeps LEDs defined.
    end else begin
      o_valid <= 1'b0;  // Pulse by default off.
      if (i_tick) begin
        case (state)
          RX_IDLE: begin
            if (!rxd_sync) begin  // Possible start edge.
              state    <= RX_START;
              tick_cnt <= '0;
            end
          end
          RX_START: begin
            if (tick_cnt == TICK_MID) begin
              tick_cnt <= '0;
              bit_cnt  <= '0;
              // Still low at mid bit, real start. Otherwise a glitch.
              state    <= rxd_sync ? RX_IDLE : RX_DATA;
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
          RX_DATA: begin
            if (tick_cnt == TICK_LAST) begin
              tick_cnt <= '0;
              if (bit_cnt == BIT_LAST) begin
                state <= RX_STOP;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
              end
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
          RX_STOP: begin
            if (tick_cnt == TICK_LAST) begin  // Middle of first stop bit.
              state <= RX_IDLE;
              if (rxd_sync) begin  // Bad stop bit drops the frame.
                o_valid <= 1'b1;
                o_data  <= shift_reg;
              end
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
          default: state <= RX_IDLE;
        endcase
      end
    end
  end

  // Data shifter, MSB enters last.
  always_ff @(posedge i_clock) begin
    if (i_tick && (state == RX_DATA) && (tick_cnt == TICK_LAST)) begin
      shift_reg <= {rxd_sync, shift_reg[DATA_BITS-1:1]};
    end
  end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx
  import uart_alu_pkg::*;
(
  input  logic  i_clock,  // System clock.
  input  logic  i_rst_n,  // Sync reset, active low.
  input  logic  i_tick,   // Oversampling strobe.
  input  byte_t i_data,   // Byte to send.
  input  logic  i_valid,  // Byte offered.
  output logic  o_ready,  // Idle, byte can be taken.
  output logic  o_txd     // Serial line, idle high.
);

  tx_state_t state;
  tick_cnt_t tick_cnt;   // Ticks into the current bit.
  bit_cnt_t  bit_cnt;    // Data or stop bit index.
  byte_t     shift_reg;  // Outgoing byte, LSB at bit 0.
  logic      xfer;       // Handshake completes.
  logic      bit_end;    // Last tick of a bit.

  assign o_ready = (state == TX_IDLE);
  assign xfer    = i_valid && o_ready;
  assign bit_end = i_tick && (tick_cnt == TICK_LAST);

  ////////////////////////////////////////////////////////////////////////////
  // Frame FSM. Line updates only on ticks so bits align to the tick grid.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      state    <= TX_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      o_txd    <= 1'b1;
    end else if (xfer) begin
      state    <= TX_START;  // Start bit from the next tick.
      tick_cnt <= '0;
      bit_cnt  <= '0;
    end else if (i_tick) begin
      case (state)
        TX_IDLE:  o_txd <= 1'b1;
        TX_START: o_txd <= 1'b0;
        TX_DATA:  o_txd <= shift_reg[0];
        TX_STOP:  o_txd <= 1'b1;
        default:  o_txd <= 1'b1;
      endcase
      if (state != TX_IDLE) begin
        tick_cnt <= tick_cnt + 1'b1;  // Wraps at 16.
      end
      if (bit_end) begin
        case (state)
          TX_START: state <= TX_DATA;
          TX_DATA: begin
            if (bit_cnt == BIT_LAST) begin
              state   <= TX_STOP;
              bit_cnt <= '0;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
          TX_STOP: begin
            if (bit_cnt == STOP_LAST) begin
              state <= TX_IDLE;  // Ready again.
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
          default: state <= TX_IDLE;
        endcase
      end
    end
  end

  // Load on transfer, shift after each data bit.
  always_ff @(posedge i_clock) begin
    if (xfer) begin
      shift_reg <= i_data;
    end else if (bit_end && (state == TX_DATA)) begin
      shift_reg <= {1'b0, shift_reg[DATA_BITS-1:1]};
    end
  end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu
  import uart_alu_pkg::*;
(
  input  byte_t   i_opnd_a,  // Operand A.
  input  byte_t   i_opnd_b,  // Operand B, shift amount for shifts.
  input  opcode_t i_opcode,  // Operation select.
  output byte_t   o_result   // Eight bit result.
);

  logic [2:0] shamt;  // Only the low bits of B shift.

  assign shamt = i_opnd_b[2:0];

  ////////////////////////////////////////////////////////////////////////////
  // Opcode decode.
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (i_opcode)
      OP_ADD:  o_result = i_opnd_a + i_opnd_b;  // Carry dropped.
      OP_SUB:  o_result = i_opnd_a - i_opnd_b;  // Borrow dropped.
      OP_AND:  o_result = i_opnd_a & i_opnd_b;
      OP_OR:   o_result = i_opnd_a | i_opnd_b;
      OP_XOR:  o_result = i_opnd_a ^ i_opnd_b;
      OP_NOR:  o_result = ~(i_opnd_a | i_opnd_b);
      OP_SRL:  o_result = i_opnd_a >> shamt;  // Zero fill.
      OP_SRA:  o_result = byte_t'($signed(i_opnd_a) >>> shamt);  // Sign fill.
      default: o_result = '0;  // Unknown opcode.
    endcase
  end

endmodule

/* source/alu_frame_ctrl.sv */
`timescale 1ns/1ps

module alu_frame_ctrl
  import uart_alu_pkg::*;
(
  input  logic    i_clock,     // System clock.
  input  logic    i_rst_n,     // Sync reset, active low.
  input  byte_t   i_rx_data,   // Received byte.
  input  logic    i_rx_valid,  // Received byte strobe.
  input  byte_t   i_result,    // ALU result.
  output byte_t   o_opnd_a,    // Operand A to ALU.
  output byte_t   o_opnd_b,    // Operand B to ALU.
  output opcode_t o_opcode,    // Opcode to ALU.
  output byte_t   o_tx_data,   // Reply byte.
  output logic    o_tx_valid,  // Reply offered.
  input  logic    i_tx_ready   // Transmitter idle.
);

  ctrl_state_t state;
  logic        tx_done;  // Reply taken this clock.

  assign tx_done = o_tx_valid && i_tx_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Command sequencer. A, B, opcode, then one reply.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      state      <= C_GET_A;
      o_tx_valid <= 1'b0;
    end else begin
      case (state)
        C_GET_A: begin
          if (i_rx_valid) begin
            state <= C_GET_B;
          end
        end
        C_GET_B: begin
          if (i_rx_valid) begin
            state <= C_GET_OP;
          end
        end
        C_GET_OP: begin
          if (i_rx_valid) begin
            state <= C_SEND;
          end
        end
        C_SEND: begin  // Incoming bytes are ignored here.
          if (tx_done) begin
            o_tx_valid <= 1'b0;
            state      <= C_GET_A;
          end else begin
            o_tx_valid <= 1'b1;  // First clock raises it.
          end
        end
        default: state <= C_GET_A;
      endcase
    end
  end

  // Operand and reply registers.
  always_ff @(posedge i_clock) begin
    if (i_rx_valid) begin
      case (state)
        C_GET_A:  o_opnd_a <= i_rx_data;
        C_GET_B:  o_opnd_b <= i_rx_data;
        C_GET_OP: o_opcode <= i_rx_data;
        default:  ;
      endcase
    end
    // Capture once, then hold while the reply waits.
    if ((state == C_SEND) && !o_tx_valid) begin
      o_tx_data <= i_result;
    end
  end

endmodule

/* source/uart_alu_top.sv */
`timescale 1ns/1ps

module uart_alu_top
  import uart_alu_pkg::*;
(
  input  logic       i_clock,     // 10 MHz system clock.
  input  logic       i_rst_n,     // Sync reset, active low.
  input  logic       i_uart_rxd,  // From host.
  output logic       o_uart_txd,  // To host.
  output logic [3:0] o_leds       // Low nibble of last byte.
);

  logic    tick;      // Oversampling strobe.
  byte_t   rx_data;   // Byte from receiver.
  logic    rx_valid;
  byte_t   opnd_a;
  byte_t   opnd_b;
  opcode_t opcode;
  byte_t   result;    // ALU output.
  byte_t   tx_data;   // Reply to transmitter.
  logic    tx_valid;
  logic    tx_ready;

  assign o_leds = rx_data[3:0];  // Held until next good frame.

  ////////////////////////////////////////////////////////////////////////////
  // Block instances.
  ////////////////////////////////////////////////////////////////////////////

  baud_tick_gen u_baud_tick_gen (
    .i_clock (i_clock),
    .i_rst_n (i_rst_n),
    .o_tick  (tick)
  );

  uart_rx u_uart_rx (
    .i_clock (i_clock),
    .i_rst_n (i_rst_n),
    .i_tick  (tick),
    .i_rxd   (i_uart_rxd),
    .o_data  (rx_data),
    .o_valid (rx_valid)
  );

  alu_frame_ctrl u_alu_frame_ctrl (
    .i_clock    (i_clock),
    .i_rst_n    (i_rst_n),
    .i_rx_data  (rx_data),
    .i_rx_valid (rx_valid),
    .i_result   (result),
    .o_opnd_a   (opnd_a),
    .o_opnd_b   (opnd_b),
    .o_opcode   (opcode),
    .o_tx_data  (tx_data),
    .o_tx_valid (tx_valid),
    .i_tx_ready (tx_ready)
  );

  alu u_alu (
    .i_opnd_a (opnd_a),
    .i_opnd_b (opnd_b),
    .i_opcode (opcode),
    .o_result (result)
  );

  uart_tx u_uart_tx (
    .i_clock (i_clock),
    .i_rst_n (i_rst_n),
    .i_tick  (tick),
    .i_data  (tx_data),
    .i_valid (tx_valid),
    .o_ready (tx_ready),
    .o_txd   (o_uart_txd)
  );

endmodule

/* tests/uart_alu_asserts.sv */
`timescale 1ns/1ps

module uart_alu_asserts
  import uart_alu_pkg::*;
(
  input  logic  i_clock,     // System clock.
  input  logic  i_rst_n,     // Sync reset, active low.
  input  logic  i_tx_valid,  // Reply offered.
  input  logic  i_tx_ready,  // Transmitter idle.
  input  byte_t i_tx_data,   // Reply byte.
  input  logic  i_tx_idle,   // Transmitter FSM in TX_IDLE.
  input  logic  i_txd,       // Serial line out.
  input  logic  i_rx_valid,  // Received byte strobe.
  input  logic  i_in_send    // Controller FSM in C_SEND.
);

  // Reply byte frozen until the transmitter takes it.
  a_tx_data_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    (i_tx_valid && !i_tx_ready) |=> (i_tx_valid && $stable(i_tx_data)))
    else $error("tx_data changed or tx_valid fell before the transfer");

  a_txd_idle_high: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    i_tx_idle |-> i_txd)  // Line marks while idle.
    else $error("o_txd low while the transmitter is idle");

  // Command/reply protocol, no byte during the reply handoff.
  a_no_rx_in_send: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    i_in_send |-> !i_rx_valid)
    else $error("rx_valid pulsed while the controller was in C_SEND");

endmodule

bind alu_frame_ctrl uart_alu_asserts u_ctrl_asserts (
  .i_clock (i_clock), .i_rst_n (i_rst_n),
  .i_tx_valid (o_tx_valid), .i_tx_ready (i_tx_ready), .i_tx_data (o_tx_data),
  .i_tx_idle (1'b0), .i_txd (1'b1),  // No line here.
  .i_rx_valid (i_rx_valid), .i_in_send (state == C_SEND)
);

bind uart_tx uart_alu_asserts u_tx_asserts (
  .i_clock (i_clock), .i_rst_n (i_rst_n),
  .i_tx_valid (i_valid), .i_tx_ready (o_ready), .i_tx_data (i_data),
  .i_tx_idle (state == TX_IDLE), .i_txd (o_txd),
  .i_rx_valid (1'b0), .i_in_send (1'b0)  // No receive side here.
);

/* tests/uart_alu_tb.sv */
`timescale 1ns/1ps

module uart_alu_tb
  import uart_alu_pkg::*;
();

  localparam int CLK_PERIOD = 100;                      // 10 MHz.
  localparam int BIT_CLKS   = BAUD_DIV * OVERSAMPLE;    // 80 clocks.
  localparam int FRAME_CLKS = BIT_CLKS * (1 + DATA_BITS + STOP_BITS);
  localparam int IDLE_CLKS  = 2000;
  localparam int NUM_RAND   = 20;
  localparam int NUM_FRAMES = 4 * (8 + 1 + 1 + NUM_RAND) + 1;  // Three in, one out.
  localparam int WATCHDOG_CLKS = NUM_FRAMES * FRAME_CLKS + IDLE_CLKS + 5000;
  localparam opcode_t VALID_OPS [8] = '{OP_ADD, OP_SUB, OP_AND, OP_OR,
                                        OP_XOR, OP_NOR, OP_SRL, OP_SRA};

  logic        i_clock = 1'b0;
  logic        i_rst_n;
  logic        i_uart_rxd;
  logic        o_uart_txd;
  logic [3:0]  o_leds;
  int          err_count = 0;
  logic [31:0] lcg_state = 32'd89396;  // Fixed seed.

  uart_alu_top i_uart_alu_top (
    .i_clock    (i_clock),
    .i_rst_n    (i_rst_n),
    .i_uart_rxd (i_uart_rxd),
    .o_uart_txd (o_uart_txd),
    .o_leds     (o_leds)
  );

  always #(CLK_PERIOD / 2) i_clock = ~i_clock;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers.
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic check(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      err_count++;
      $display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
      report_failure();
    end
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Reference results straight from the opcode table.
  function automatic byte_t expected_result(byte_t a, byte_t b, opcode_t op);
    logic [15:0] sext;  // A sign extended, then shifted.
    sext = {{8{a[7]}}, a} >> b[2:0];
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_NOR:  return ~(a | b);
      OP_SRL:  return a >> b[2:0];
      OP_SRA:  return sext[7:0];
      default: return 8'h00;
    endcase
  endfunction

  task automatic drive_bit(input logic value);
    i_uart_rxd <= value;  // Held one bit time.
    repeat (BIT_CLKS) @(posedge i_clock);
  endtask

  // Start, 8 data bits LSB first, 2 stop bits.
  task automatic send_byte(input byte_t data, input logic stop_ok);
    @(posedge i_clock);
    drive_bit(1'b0);
    for (int i = 0; i < DATA_BITS; i++) begin
      drive_bit(data[i]);
    end
    drive_bit(stop_ok);  // Low here gives a framing error.
    drive_bit(1'b1);
  endtask

  // Samples on falling clock edges, away from DUT updates.
  task automatic recv_byte(output byte_t data);
    byte_t bits;
    @(negedge i_clock);
    while (o_uart_txd) @(negedge i_clock);  // Start edge.
    repeat (BIT_CLKS / 2) @(negedge i_clock);
    check("o_uart_txd start bit", byte_t'(o_uart_txd), 8'h00);
    for (int i = 0; i < DATA_BITS; i++) begin
      repeat (BIT_CLKS) @(negedge i_clock);
      bits[i] = o_uart_txd;
    end
    for (int i = 0; i < STOP_BITS; i++) begin
      repeat (BIT_CLKS) @(negedge i_clock);
      check("o_uart_txd stop bit", byte_t'(o_uart_txd), 8'h01);
    end
    data = bits;
  endtask

  task automatic run_command(input byte_t a, input byte_t b, input opcode_t op,
                             output byte_t reply);
    fork
      begin
        send_byte(a, 1'b1);
        send_byte(b, 1'b1);
        send_byte(op, 1'b1);
      end
      recv_byte(reply);
    join
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests.
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_idle_line();
    repeat (IDLE_CLKS) begin
      @(negedge i_clock);
      check("o_uart_txd idle", byte_t'(o_uart_txd), 8'h01);
    end
  endtask

  // Operands chosen so every opcode gives a distinct, nonzero reply.
  task automatic test_each_opcode();
    byte_t a;
    byte_t b;
    byte_t reply;
    foreach (VALID_OPS[i]) begin
      a = (VALID_OPS[i] inside {OP_SRL, OP_SRA}) ? 8'h80 : 8'hF0;  // Sign bit set.
      b = (VALID_OPS[i] inside {OP_SRL, OP_SRA}) ? 8'h03 : 8'h3C;
      run_command(a, b, VALID_OPS[i], reply);
      check("o_uart_txd reply", reply, expected_result(a, b, VALID_OPS[i]));
      check("o_leds", byte_t'(o_leds), byte_t'(VALID_OPS[i][3:0]));  // Last byte.
    end
  endtask

  task automatic test_unknown_opcode();
    byte_t reply;
    run_command(8'hF0, 8'h3C, 8'h55, reply);
    check("o_uart_txd reply", reply, 8'h00);
    check("o_leds", byte_t'(o_leds), 8'h05);
  endtask

  task automatic test_bad_stop_bit();
    logic [3:0] leds_before;
    byte_t      reply;
    @(negedge i_clock);
    leds_before = o_leds;
    send_byte(8'h3C, 1'b0);  // Must be dropped.
    @(negedge i_clock);
    check("o_leds after bad frame", byte_t'(o_leds), byte_t'(leds_before));
    run_command(8'h12, 8'h34, OP_ADD, reply);  // Misaligned would give 0x00.
    check("o_uart_txd reply", reply, expected_result(8'h12, 8'h34, OP_ADD));
  endtask

  task automatic test_random_burst();
    byte_t       a_arr  [NUM_RAND];
    byte_t       b_arr  [NUM_RAND];
    opcode_t     op_arr [NUM_RAND];
    byte_t       reply;
    logic [31:0] r;
    for (int i = 0; i < NUM_RAND; i++) begin
      r = next_rand();
      a_arr[i] = r[23:16];
      r = next_rand();
      b_arr[i] = r[23:16];
      r = next_rand();
      op_arr[i] = VALID_OPS[r[18:16]];
    end
    fork
      for (int i = 0; i < NUM_RAND; i++) begin  // Commands back to back.
        send_byte(a_arr[i], 1'b1);
        send_byte(b_arr[i], 1'b1);
        send_byte(op_arr[i], 1'b1);
      end
      for (int i = 0; i < NUM_RAND; i++) begin
        recv_byte(reply);
        check("o_uart_txd burst reply", reply,
              expected_result(a_arr[i], b_arr[i], op_arr[i]));
      end
    join
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence and watchdog.
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    #(WATCHDOG_CLKS * CLK_PERIOD);
    $display("Timeout, the tests did not finish within %0d clocks.", WATCHDOG_CLKS);
    report_failure();
  end

  initial begin
    i_rst_n    <= 1'b0;
    i_uart_rxd <= 1'b1;  // Line idles high.
    repeat (8) @(posedge i_clock);
    i_rst_n <= 1'b1;
    test_idle_line();
    test_each_opcode();
    test_unknown_opcode();
    test_bad_stop_bit();
    test_random_burst();
    if (err_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      report_failure();
    end
  end

endmodule

/* uart_alu.f */
source/uart_alu_pkg.sv
source/baud_tick_gen.sv
source/uart_rx.sv
source/uart_tx.sv
source/alu.sv
source/alu_frame_ctrl.sv
source/uart_alu_top.sv
tests/uart_alu_asserts.sv
tests/uart_alu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run, then look for the pass line in the output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module uart_alu_tb -f uart_alu.f \
  -o uart_alu_sim &&
{ out=$(./obj_dir/uart_alu_sim 2>&1); printf '%s\n' "$out"; } &&
printf '%s\n' "$out" | grep -q "^ALL TESTS PASSED$" &&
echo "run_sim.sh: simulation passed" ||
{ echo "run_sim.sh: simulation failed"; exit 1; }
